// ==== pipe_cpu.f ====
isa_pkg.sv
pipe_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
pipe_cpu.sv
pipe_cpu_props.sv
tb_pipe_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pipe_cpu -f pipe_cpu.f -o sim_pipe_cpu

# verdict comes from the printed result
result=$(./obj_dir/sim_pipe_cpu 2>&1) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx 'TB PASSED'; then
    exit 0
fi
exit 1

// ==== tb_pipe_cpu.sv ====
`timescale 1ns/1ps

module tb_pipe_cpu import isa_pkg::*; ();

    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 64;
    localparam int PROG_LEN     = 40;
    localparam int BODY_LEN     = PROG_LEN - 9;     // then 8 register dumps and HLT
    localparam int NUM_PROGS    = 20;
    localparam int RESET_CYCLES = 8;
    localparam int RUN_LIMIT    = 10 * PROG_LEN;
    localparam int SEED         = 17419;

    logic  clk;
    logic  rst_n;
    logic  run;
    logic  prog_we;
    word_t prog_addr;
    word_t prog_data;
    word_t in_port;
    logic  out_valid;
    word_t out_data;
    logic  halted;

    word_t prog [PROG_LEN];
    word_t exp_out [$];     // model output sequence
    int    gen_pos;

    pipe_cpu #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .in_port   (in_port),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    task automatic fail_run(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic word_t encode(opcode_t op, int rd, int rs, int imm);
        return {op, rd[2:0], rs[2:0], imm[5:0]};
    endfunction

    function automatic opcode_t pick_alu_op(int sel);
        case (sel)
            0:       return OP_ADD;
            1:       return OP_SUB;
            2:       return OP_AND;
            3:       return OP_OR;
            4:       return OP_NOT;
            default: return OP_SHL;
        endcase
    endfunction

    task automatic emit(word_t instr);
        if (gen_pos < BODY_LEN) begin
            prog[gen_pos] = instr;
            gen_pos++;
        end
    endtask

    // forward only and never past the register dump
    function automatic int branch_offset();
        int off;
        off = $urandom_range(0, 5);
        if (gen_pos + 1 + off > BODY_LEN)
            off = BODY_LEN - gen_pos - 1;
        return off;
    endfunction

    task automatic build_program();
        int kind;
        int rd;
        int rs;
        int other;
        gen_pos = 0;
        while (gen_pos < BODY_LEN) begin
            kind  = $urandom_range(0, 99);
            rd    = $urandom_range(0, 7);
            rs    = $urandom_range(0, 7);
            other = $urandom_range(0, 7);
            if (kind < 12) begin
                emit(encode(OP_LDI, rd, 0, $urandom_range(0, 63)));
            end else if (kind < 18) begin
                emit(encode(OP_IN, rd, 0, 0));
            end else if (kind < 44) begin
                emit(encode(pick_alu_op($urandom_range(0, 5)), rd, rs, 0));
            end else if (kind < 52) begin
                emit(encode(OP_ST, rd, rs, 0));
                if ($urandom_range(0, 1) == 1)
                    emit(encode(OP_LD, other, rs, 0));  // read back the same address
            end else if (kind < 64) begin
                emit(encode(OP_LD, rd, rs, 0));
                // loaded register used right away
                case ($urandom_range(0, 3))
                    0:       emit(encode(OP_ADD, other, rd, 0));
                    1:       emit(encode(OP_OUT, 0, rd, 0));
                    2:       emit(encode(OP_ADD, rd, other, 0));
                    default: emit(encode(OP_ST, rd, other, 0));
                endcase
            end else if (kind < 76) begin
                emit(encode(OP_OUT, 0, rs, 0));
            end else if (kind < 88) begin
                if ($urandom_range(0, 1) == 1)
                    emit(encode(OP_SUB, rd, rd, 0));    // sets zero so the branch is taken
                emit(encode(OP_JZ, 0, 0, branch_offset()));
            end else if (kind < 93) begin
                emit(encode(OP_JMP, 0, 0, branch_offset()));
            end else if (kind < 96) begin
                emit(encode(OP_NOP, 0, 0, 0));
            end else begin
                emit(encode(OP_LD, rd, rs, 0));
            end
        end
        for (int r = 0; r < 8; r++)
            prog[BODY_LEN + r] = encode(OP_OUT, 0, r, 0);   // final register state
        prog[PROG_LEN - 1] = encode(OP_HLT, 0, 0, 0);
    endtask

    // sequential reference, one instruction per step
    task automatic run_model(word_t in_val);
        word_t     regs [8];
        word_t     dmem [DMEM_DEPTH];
        word_t     instr;
        word_t     res;
        opcode_t   op;
        reg_addr_t rd;
        reg_addr_t rs;
        logic      zero;
        logic      done;
        int        pc;
        int        next_pc;
        for (int r = 0; r < 8; r++)
            regs[r] = '0;
        for (int a = 0; a < DMEM_DEPTH; a++)
            dmem[a] = '0;
        zero = 1'b0;
        done = 1'b0;
        pc   = 0;
        exp_out.delete();
        while (!done) begin
            if (pc >= PROG_LEN)
                fail_run("model ran past the end of the program");
            instr   = prog[pc];
            op      = instr[15:12];
            rd      = instr[11:9];
            rs      = instr[8:6];
            next_pc = pc + 1;
            res     = '0;
            case (op)
                OP_ADD:  res = regs[rd] + regs[rs];
                OP_SUB:  res = regs[rd] - regs[rs];
                OP_AND:  res = regs[rd] & regs[rs];
                OP_OR:   res = regs[rd] | regs[rs];
                OP_NOT:  res = ~regs[rs];
                OP_SHL:  res = regs[rs] << 1;
                OP_LDI:  regs[rd] = {{10{instr[5]}}, instr[5:0]};
                OP_LD:   regs[rd] = dmem[int'(regs[rs]) % DMEM_DEPTH];
                OP_ST:   dmem[int'(regs[rs]) % DMEM_DEPTH] = regs[rd];
                OP_IN:   regs[rd] = in_val;
                OP_OUT:  exp_out.push_back(regs[rs]);
                OP_JZ:   if (zero) next_pc = pc + 1 + int'($signed(instr[5:0]));
                OP_JMP:  next_pc = pc + 1 + int'($signed(instr[5:0]));
                OP_HLT:  done = 1'b1;
                default: ;
            endcase
            // only the ALU group writes the flags
            if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_SHL}) begin
                regs[rd] = res;
                zero     = (res == '0);
            end
            pc = next_pc;
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            prog_we   = 1'b1;
            prog_addr = 16'(a);
            if (a < PROG_LEN)
                prog_data = prog[a];
            else
                prog_data = encode(OP_HLT, 0, 0, 0);    // padding past the program
            @(negedge clk);
            check_eq("out_valid", 32'(out_valid), 32'd0);
            check_eq("halted", 32'(halted), 32'd0);
        end
        prog_we = 1'b0;
    endtask

    task automatic wait_for_halt(int prog_idx);
        int got;
        int cycles;
        got    = 0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (out_valid) begin
                if (got >= exp_out.size())
                    fail_run($sformatf("program %0d gave more OUT results than expected",
                                       prog_idx));
                check_eq("out_data", 32'(out_data), 32'(exp_out[got]));
                got++;
            end
            if (cycles > RUN_LIMIT && !halted)
                fail_run($sformatf("program %0d did not halt within %0d cycles",
                                   prog_idx, RUN_LIMIT));
        end while (!halted);
        check_eq("output count", 32'(got), 32'(exp_out.size()));
        // pipeline must stay quiet once halted
        repeat (4) begin
            @(negedge clk);
            check_eq("out_valid", 32'(out_valid), 32'd0);
            check_eq("halted", 32'(halted), 32'd1);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        in_port   = '0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(negedge clk);
            rst_n = 1'b0;
            run   = 1'b0;
            repeat (RESET_CYCLES) begin
                @(negedge clk);
                check_eq("out_valid", 32'(out_valid), 32'd0);
                check_eq("halted", 32'(halted), 32'd0);
            end
            rst_n   = 1'b1;
            in_port = 16'($urandom);    // held for the whole run
            build_program();
            run_model(in_port);
            load_program();
            run = 1'b1;
            wait_for_halt(p);
        end
        $display("TB PASSED");
        $finish;
    end

    // per-program budget of reset, load, run limit and tail
    initial begin
        repeat (NUM_PROGS * (1 + RESET_CYCLES + IMEM_DEPTH + RUN_LIMIT + 4) + 16)
            @(posedge clk);
        fail_run("watchdog expired before all programs finished");
    end

endmodule

// ==== pipe_cpu_props.sv ====
`timescale 1ns/1ps

module pipe_cpu_props (
    input logic clk,
    input logic rst_n,
    input logic stall,
    input logic halted,
    input logic out_valid
);

    // one bubble always clears a load-use hazard
    a_single_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> !stall
    ) else $error("stall stayed high for two cycles in a row");

    // halted is sticky until the next reset
    a_halted_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted
    ) else $error("halted fell without a reset");

    a_no_out_after_halt: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> !out_valid
    ) else $error("out_valid pulsed after halted was already high");

endmodule

bind pipe_cpu pipe_cpu_props i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .halted    (halted),
    .out_valid (out_valid)
);

// ==== pipe_cpu.sv ====
`timescale 1ns/1ps

module pipe_cpu import isa_pkg::*, pipe_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    input  logic  prog_we,
    input  word_t prog_addr,
    input  word_t prog_data,
    input  word_t in_port,
    output logic  out_valid,
    output word_t out_data,
    output logic  halted
);
    // fetch/decode
    word_t     fd_instr;
    word_t     fd_pc;
    logic      stall;

    // decode/execute
    word_t     de_pc;
    reg_addr_t de_rs;
    reg_addr_t de_rd;
    word_t     de_rs_data;
    word_t     de_rd_data;
    word_t     de_imm;
    alu_op_t   de_alu_op;
    logic      de_use_imm;
    logic      de_reg_write;
    logic      de_set_flags;
    logic      de_mem_read;
    logic      de_mem_write;
    logic      de_out;
    logic      de_branch_z;
    logic      de_jump;
    logic      de_halt;

    // execute/memory
    logic      redirect;
    word_t     redirect_pc;
    logic      halt;
    word_t     em_result;
    word_t     em_store_data;
    reg_addr_t em_rd;
    logic      em_reg_write;
    logic      em_mem_read;
    logic      em_mem_write;
    logic      em_out;

    // memory/write back
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halt        (halt),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .fd_instr    (fd_instr),
        .fd_pc       (fd_pc),
        .halted      (halted)
    );

    decode_stage i_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .fd_instr     (fd_instr),
        .fd_pc        (fd_pc),
        .flush        (redirect || halt),   // HLT also drops the younger two
        .ex_rd        (de_rd),
        .ex_mem_read  (de_mem_read),
        .in_port      (in_port),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .stall        (stall),
        .de_pc        (de_pc),
        .de_rs        (de_rs),
        .de_rd        (de_rd),
        .de_rs_data   (de_rs_data),
        .de_rd_data   (de_rd_data),
        .de_imm       (de_imm),
        .de_alu_op    (de_alu_op),
        .de_use_imm   (de_use_imm),
        .de_reg_write (de_reg_write),
        .de_set_flags (de_set_flags),
        .de_mem_read  (de_mem_read),
        .de_mem_write (de_mem_write),
        .de_out       (de_out),
        .de_branch_z  (de_branch_z),
        .de_jump      (de_jump),
        .de_halt      (de_halt)
    );

    execute_stage i_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .de_pc         (de_pc),
        .de_rs         (de_rs),
        .de_rd         (de_rd),
        .de_rs_data    (de_rs_data),
        .de_rd_data    (de_rd_data),
        .de_imm        (de_imm),
        .de_alu_op     (de_alu_op),
        .de_use_imm    (de_use_imm),
        .de_reg_write  (de_reg_write),
        .de_set_flags  (de_set_flags),
        .de_mem_read   (de_mem_read),
        .de_mem_write  (de_mem_write),
        .de_out        (de_out),
        .de_branch_z   (de_branch_z),
        .de_jump       (de_jump),
        .de_halt       (de_halt),
        .mem_rd        (em_rd),
        .mem_we        (em_reg_write),
        .mem_result    (em_result),
        .wb_rd         (wb_rd),
        .wb_we         (wb_we),
        .wb_data       (wb_data),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .halt          (halt),
        .em_result     (em_result),
        .em_store_data (em_store_data),
        .em_rd         (em_rd),
        .em_reg_write  (em_reg_write),
        .em_mem_read   (em_mem_read),
        .em_mem_write  (em_mem_write),
        .em_out        (em_out),
        .flags         ()
    );

    memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) i_memory (
        .clk           (clk),
        .rst_n         (rst_n),
        .em_result     (em_result),
        .em_store_data (em_store_data),
        .em_rd         (em_rd),
        .em_reg_write  (em_reg_write),
        .em_mem_read   (em_mem_read),
        .em_mem_write  (em_mem_write),
        .em_out        (em_out),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

// ==== memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import isa_pkg::*; #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     em_result,
    input  word_t     em_store_data,
    input  reg_addr_t em_rd,
    input  logic      em_reg_write,
    input  logic      em_mem_read,
    input  logic      em_mem_write,
    input  logic      em_out,
    output logic      out_valid,
    output word_t     out_data,
    output logic      wb_we,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);
    localparam int AW = $clog2(DMEM_DEPTH);

    word_t         dmem [DMEM_DEPTH];
    logic [AW-1:0] addr;
    word_t         load_data;

    assign addr      = em_result[AW-1:0];   // wraps to the memory size
    assign load_data = dmem[addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end else if (em_mem_write) begin
            dmem[addr] <= em_store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            wb_we     <= 1'b0;
        end else begin
            out_valid <= em_out;        // one pulse per OUT
            wb_we     <= em_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (em_out)
            out_data <= em_result;
        wb_rd   <= em_rd;
        wb_data <= em_mem_read ? load_data : em_result;
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     de_pc,
    input  reg_addr_t de_rs,
    input  reg_addr_t de_rd,
    input  word_t     de_rs_data,
    input  word_t     de_rd_data,
    input  word_t     de_imm,
    input  alu_op_t   de_alu_op,
    input  logic      de_use_imm,
    input  logic      de_reg_write,
    input  logic      de_set_flags,
    input  logic      de_mem_read,
    input  logic      de_mem_write,
    input  logic      de_out,
    input  logic      de_branch_z,
    input  logic      de_jump,
    input  logic      de_halt,
    input  reg_addr_t mem_rd,
    input  logic      mem_we,
    input  word_t     mem_result,
    input  reg_addr_t wb_rd,
    input  logic      wb_we,
    input  word_t     wb_data,
    output logic      redirect,
    output word_t     redirect_pc,
    output logic      halt,
    output word_t     em_result,
    output word_t     em_store_data,
    output reg_addr_t em_rd,
    output logic      em_reg_write,
    output logic      em_mem_read,
    output logic      em_mem_write,
    output logic      em_out,
    output flags_t    flags
);
    fwd_sel_t rs_sel;
    fwd_sel_t rd_sel;
    word_t    rs_val;
    word_t    rd_val;
    word_t    op_b;
    word_t    result;
    logic     carry;

    // memory stage is younger than write back, so it is checked first
    assign rs_sel = (mem_we && mem_rd == de_rs) ? FWD_MEM :
                    (wb_we && wb_rd == de_rs)   ? FWD_WB  : FWD_RF;
    assign rd_sel = (mem_we && mem_rd == de_rd) ? FWD_MEM :
                    (wb_we && wb_rd == de_rd)   ? FWD_WB  : FWD_RF;

    always_comb begin
        case (rs_sel)
            FWD_MEM: rs_val = mem_result;
            FWD_WB:  rs_val = wb_data;
            default: rs_val = de_rs_data;
        endcase
        case (rd_sel)
            FWD_MEM: rd_val = mem_result;
            FWD_WB:  rd_val = wb_data;
            default: rd_val = de_rd_data;
        endcase
    end

    assign op_b = de_use_imm ? de_imm : rs_val;

    always_comb begin
        carry = 1'b0;
        case (de_alu_op)
            ALU_ADD: {carry, result} = {1'b0, rd_val} + {1'b0, op_b};
            ALU_SUB: {carry, result} = {1'b0, rd_val} - {1'b0, op_b};  // borrow
            ALU_AND: result = rd_val & op_b;
            ALU_OR:  result = rd_val | op_b;
            ALU_NOT: result = ~op_b;
            ALU_SHL: {carry, result} = {op_b, 1'b0};
            default: result = op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (de_set_flags) begin
            flags[FLAG_Z] <= (result == '0);
            flags[FLAG_N] <= result[WORD_W-1];
            flags[FLAG_C] <= carry;
        end
    end

    // bubbles carry no branch, jump or halt bits
    assign redirect    = de_jump || (de_branch_z && flags[FLAG_Z]);
    assign redirect_pc = de_pc + de_imm;    // de_pc is already pc+1
    assign halt        = de_halt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            em_reg_write <= 1'b0;
            em_mem_read  <= 1'b0;
            em_mem_write <= 1'b0;
            em_out       <= 1'b0;
        end else begin
            em_reg_write <= de_reg_write;
            em_mem_read  <= de_mem_read;
            em_mem_write <= de_mem_write;
            em_out       <= de_out;
        end
    end

    always_ff @(posedge clk) begin
        em_result     <= result;
        em_store_data <= rd_val;
        em_rd         <= de_rd;
    end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     fd_instr,
    input  word_t     fd_pc,
    input  logic      flush,
    input  reg_addr_t ex_rd,
    input  logic      ex_mem_read,
    input  word_t     in_port,
    input  logic      wb_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output logic      stall,
    output word_t     de_pc,
    output reg_addr_t de_rs,
    output reg_addr_t de_rd,
    output word_t     de_rs_data,
    output word_t     de_rd_data,
    output word_t     de_imm,
    output alu_op_t   de_alu_op,
    output logic      de_use_imm,
    output logic      de_reg_write,
    output logic      de_set_flags,
    output logic      de_mem_read,
    output logic      de_mem_write,
    output logic      de_out,
    output logic      de_branch_z,
    output logic      de_jump,
    output logic      de_halt
);
    opcode_t   op;
    reg_addr_t rs;
    reg_addr_t rd;
    imm_t      imm;
    word_t     imm_ext;
    word_t     rs_data;
    word_t     rd_data;
    alu_op_t   alu_op;
    logic      set_flags;
    logic      reg_write;
    logic      use_imm;
    logic      uses_rs;
    logic      uses_rd;

    assign op  = fd_instr[15:12];
    assign rd  = fd_instr[11:9];
    assign rs  = fd_instr[8:6];
    assign imm = fd_instr[5:0];

    // IN rides through the ALU as an immediate pass
    assign imm_ext = (op == OP_IN) ? in_port : {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};

    reg_file i_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs),
        .rd_addr (rd),
        .wr_en   (wb_we),
        .wr_addr (wb_rd),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rd_data (rd_data)
    );

    always_comb begin
        case (op)
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_NOT:  alu_op = ALU_NOT;
            OP_SHL:  alu_op = ALU_SHL;
            default: alu_op = ALU_PASS;
        endcase
    end

    assign set_flags = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_SHL};
    assign reg_write = set_flags || (op inside {OP_LDI, OP_LD, OP_IN});
    assign use_imm   = op inside {OP_LDI, OP_IN};
    assign uses_rd   = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ST};
    assign uses_rs   = uses_rd || (op inside {OP_NOT, OP_SHL, OP_LD, OP_OUT});

    // the loaded word is only ready after the memory stage
    assign stall = ex_mem_read && ((uses_rs && ex_rd == rs) || (uses_rd && ex_rd == rd));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_alu_op    <= ALU_PASS;
            de_use_imm   <= 1'b0;
            de_reg_write <= 1'b0;
            de_set_flags <= 1'b0;
            de_mem_read  <= 1'b0;
            de_mem_write <= 1'b0;
            de_out       <= 1'b0;
            de_branch_z  <= 1'b0;
            de_jump      <= 1'b0;
            de_halt      <= 1'b0;
        end else if (stall || flush) begin  // bubble
            de_alu_op    <= ALU_PASS;
            de_use_imm   <= 1'b0;
            de_reg_write <= 1'b0;
            de_set_flags <= 1'b0;
            de_mem_read  <= 1'b0;
            de_mem_write <= 1'b0;
            de_out       <= 1'b0;
            de_branch_z  <= 1'b0;
            de_jump      <= 1'b0;
            de_halt      <= 1'b0;
        end else begin
            de_alu_op    <= alu_op;
            de_use_imm   <= use_imm;
            de_reg_write <= reg_write;
            de_set_flags <= set_flags;
            de_mem_read  <= (op == OP_LD);
            de_mem_write <= (op == OP_ST);
            de_out       <= (op == OP_OUT);
            de_branch_z  <= (op == OP_JZ);
            de_jump      <= (op == OP_JMP);
            de_halt      <= (op == OP_HLT);
        end
    end

    always_ff @(posedge clk) begin
        de_pc      <= fd_pc;
        de_rs      <= rs;
        de_rd      <= rd;
        de_rs_data <= rs_data;
        de_rd_data <= rd_data;
        de_imm     <= imm_ext;
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rd_addr,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rd_data
);
    word_t regs [8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so decode sees the value written back this cycle
    assign rs_data = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rd_data = (wr_en && wr_addr == rd_addr) ? wr_data : regs[rd_addr];

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import isa_pkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  logic  halt,
    input  logic  prog_we,
    input  word_t prog_addr,
    input  word_t prog_data,
    output word_t fd_instr,
    output word_t fd_pc,
    output logic  halted
);
    localparam int    AW        = $clog2(IMEM_DEPTH);
    localparam word_t NOP_INSTR = {OP_NOP, 12'h000};

    word_t imem [IMEM_DEPTH];
    word_t pc;
    word_t fetched;

    assign fetched = imem[pc[AW-1:0]];  // async read

    // program load port
    always_ff @(posedge clk) begin
        if (prog_we)
            imem[prog_addr[AW-1:0]] <= prog_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            fd_instr <= NOP_INSTR;
            fd_pc    <= '0;
        end else if (!run) begin
            pc       <= '0;             // start over at address 0
            fd_instr <= NOP_INSTR;
        end else if (redirect) begin
            pc       <= redirect_pc;
            fd_instr <= NOP_INSTR;      // kill the wrong-path fetch
        end else if (halt || halted) begin
            fd_instr <= NOP_INSTR;      // nothing past HLT goes on
        end else if (!stall) begin
            pc       <= pc + 16'd1;
            fd_instr <= fetched;
            fd_pc    <= pc + 16'd1;     // branch base is pc+1
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            halted <= 1'b0;
        else if (halt)
            halted <= 1'b1;
    end

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

    typedef logic [2:0] alu_op_t;
    typedef logic [1:0] fwd_sel_t;
    typedef logic [2:0] flags_t;

    // alu functions, a is the rd operand and b the rs or immediate operand
    localparam alu_op_t ALU_PASS = 3'd0;  // result = b
    localparam alu_op_t ALU_ADD  = 3'd1;
    localparam alu_op_t ALU_SUB  = 3'd2;
    localparam alu_op_t ALU_AND  = 3'd3;
    localparam alu_op_t ALU_OR   = 3'd4;
    localparam alu_op_t ALU_NOT  = 3'd5;
    localparam alu_op_t ALU_SHL  = 3'd6;

    // operand source in execute
    localparam fwd_sel_t FWD_RF  = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

    // flag bit positions
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

    localparam int WORD_W = 16;
    localparam int REG_AW = 3;
    localparam int OP_W   = 4;
    localparam int IMM_W  = 6;

    typedef logic [WORD_W-1:0]       word_t;      // data word, also one instruction
    typedef logic [REG_AW-1:0]       reg_addr_t;
    typedef logic [OP_W-1:0]         opcode_t;
    typedef logic signed [IMM_W-1:0] imm_t;

    // instruction layout: op[15:12] rd[11:9] rs[8:6] imm[5:0]
    localparam opcode_t OP_NOP = 4'h0;
    localparam opcode_t OP_ADD = 4'h1;  // rd = rd + rs
    localparam opcode_t OP_SUB = 4'h2;  // rd = rd - rs, carry is the borrow
    localparam opcode_t OP_AND = 4'h3;
    localparam opcode_t OP_OR  = 4'h4;
    localparam opcode_t OP_NOT = 4'h5;  // rd = ~rs
    localparam opcode_t OP_SHL = 4'h6;  // rd = rs << 1, carry = rs[15]
    localparam opcode_t OP_LDI = 4'h7;  // rd = sext(imm)
    localparam opcode_t OP_LD  = 4'h8;  // rd = dmem[rs]
    localparam opcode_t OP_ST  = 4'h9;  // dmem[rs] = rd
    localparam opcode_t OP_IN  = 4'ha;  // rd = in_port
    localparam opcode_t OP_OUT = 4'hb;  // out_data = rs
    localparam opcode_t OP_JZ  = 4'hc;  // if Z: pc = own pc + 1 + imm
    localparam opcode_t OP_JMP = 4'hd;
    localparam opcode_t OP_HLT = 4'he;

endpackage
